/* hdl/obj_pkg.sv */
/*
 * object line engine shared definitions
 * table geometry, pixel widths, transparent colour code
 * and the scanner and drawer state encodings
 */
package obj_pkg;

    // frame table geometry
    localparam int table_aw = 10;    // 1024 entries
    localparam int word_w   = 16;    // x, y, code, attr words
    localparam int entry_w  = 4 * word_w;

    // screen geometry
    localparam int hpos_w = 9;       // 512 pixel line
    localparam int vpos_w = 9;

    // stored pixel: palette[8:4], colour[3:0]
    localparam int pix_w = 9;
    localparam logic [3:0] transp_color = 4'hf;  // colour 15 is see-through

    // table walker states
    typedef enum logic [2:0] {
        scan_idle,
        scan_fetch,       // table read in flight
        scan_check,       // words valid, matcher working
        scan_wait_draw,   // zone result valid, wait for drawer
        scan_issue,
        scan_next_tile
    } scan_state_e;

    // tile drawer states
    typedef enum logic [1:0] {
        draw_idle,
        draw_fetch_row,
        draw_write
    } draw_state_e;

endpackage

/* hdl/obj_frame_table.sv */
/*
 * object frame table
 * one 64-bit entry per object, written by the host
 * scan port is registered, entry split into x, y, code, attr
 */
`timescale 1ns/1ps

module obj_frame_table #(
    parameter int table_depth = 1024
) (
    input  logic                          clk,

    // host side
    input  logic                          we,
    input  logic [obj_pkg::table_aw-1:0]  waddr,
    input  logic [obj_pkg::entry_w-1:0]   wdata,

    // scanner side
    input  logic [obj_pkg::table_aw-1:0]  raddr,
    output logic [obj_pkg::word_w-1:0]    x,
    output logic [obj_pkg::word_w-1:0]    y,
    output logic [obj_pkg::word_w-1:0]    code,
    output logic [obj_pkg::word_w-1:0]    attr
);

    logic [obj_pkg::entry_w-1:0] mem [table_depth];
    logic [obj_pkg::entry_w-1:0] rd_q;   // registered entry

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        rd_q <= mem[raddr];              // one cycle read
    end

    // word order inside an entry: x lowest, attr highest
    assign x    = rd_q[obj_pkg::word_w-1:0];
    assign y    = rd_q[2*obj_pkg::word_w-1 -: obj_pkg::word_w];
    assign code = rd_q[3*obj_pkg::word_w-1 -: obj_pkg::word_w];
    assign attr = rd_q[4*obj_pkg::word_w-1 -: obj_pkg::word_w];

endmodule

/* hdl/obj_tile_match.sv */
/*
 * vertical zone test for one object
 * checks the line against the object height, picks the tile row
 * and the row inside the tile, and sums the tile code
 * all results are registered, one cycle after the inputs
 */
`timescale 1ns/1ps

module obj_tile_match (
    input  logic                        clk,

    input  logic [15:0]                 obj_code,
    input  logic [obj_pkg::vpos_w-1:0]  obj_y,
    input  logic [3:0]                  tile_m,    // tiles down - 1
    input  logic [3:0]                  tile_n,    // tiles across - 1
    input  logic [3:0]                  n,         // horizontal tile index
    input  logic                        vflip,
    input  logic [obj_pkg::vpos_w-1:0]  vrenderf,  // line, screen flip applied

    output logic                        inzone,
    output logic [3:0]                  vsub,
    output logic [15:0]                 code_mn
);

    logic [obj_pkg::vpos_w-1:0] offset;
    logic [3:0] m_raw;
    logic [3:0] m;
    logic [3:0] n_eff;

    assign offset = vrenderf - obj_y;    // wraps mod 512
    assign m_raw  = offset[7:4];         // tile row counted from the top
    assign m      = vflip ? tile_m - m_raw : m_raw;  // rows swap under vflip
    assign n_eff  = (n > tile_n) ? tile_n : n;        // stay inside the object

    always_ff @(posedge clk) begin
        // offset < 16*(tile_m+1)
        inzone  <= offset[obj_pkg::vpos_w-1:4] <= (obj_pkg::vpos_w-4)'(tile_m);
        vsub    <= vflip ? ~offset[3:0] : offset[3:0];
        code_mn <= obj_code + {12'd0, n_eff} + {8'd0, m, 4'd0};
    end

endmodule

/* hdl/obj_scan.sv */
/*
 * per-line object table walker
 * on a line start it walks the frame table from entry 0, keeps
 * objects crossing the line and breaks them into 16 pixel tiles,
 * one draw request per on-screen tile
 * stops at the end marker or after the last address
 */
`timescale 1ns/1ps

module obj_scan #(
    parameter int table_depth = 1024
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flip,
    input  logic [obj_pkg::vpos_w-1:0]    vrender,
    input  logic                          start,

    // frame table
    output logic [obj_pkg::table_aw-1:0]  table_addr,
    input  logic [obj_pkg::word_w-1:0]    table_x,
    input  logic [obj_pkg::word_w-1:0]    table_y,
    input  logic [obj_pkg::word_w-1:0]    table_code,
    input  logic [obj_pkg::word_w-1:0]    table_attr,

    // tile matcher
    input  logic                          inzone,
    input  logic [3:0]                    vsub,
    input  logic [15:0]                   code_mn,
    output logic [3:0]                    n,
    output logic [obj_pkg::vpos_w-1:0]    vrenderf,

    // drawer
    output logic                          dr_start,
    input  logic                          dr_idle,
    output logic [15:0]                   dr_code,
    output logic [15:0]                   dr_attr,
    output logic [obj_pkg::hpos_w-1:0]    dr_hpos,

    output logic                          busy,
    output logic                          newline   // line_start edge, swaps the buffer
);

    obj_pkg::scan_state_e state;

    logic last_start;
    logic end_mark;
    logic last_addr;
    logic hflip;
    logic [3:0] tile_n;
    logic [3:0] tile_m;
    logic [3:0] npos;                       // tile x slot, reversed under hflip
    logic [obj_pkg::hpos_w:0] eff_x;        // bit 9 set means off screen

    assign newline   = start & ~last_start;
    assign tile_m    = table_attr[15:12];
    assign tile_n    = table_attr[11:8];
    assign hflip     = table_attr[5];
    assign end_mark  = table_y[15] || (table_attr[15:8] == 8'hff);
    assign last_addr = (table_addr == obj_pkg::table_aw'(table_depth - 1));
    assign npos      = hflip ? tile_n - n : n;
    assign eff_x     = table_x[obj_pkg::hpos_w:0] + {2'b00, npos, 4'd0};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= obj_pkg::scan_idle;
            table_addr <= '0;
            n          <= '0;
            dr_start   <= 1'b0;
            busy       <= 1'b0;
            last_start <= 1'b0;
        end else begin
            last_start <= start;
            dr_start   <= 1'b0;                 // single cycle request
            case (state)
                obj_pkg::scan_idle: ;
                obj_pkg::scan_fetch:
                    state <= obj_pkg::scan_check;
                obj_pkg::scan_check:            // table words valid here
                    state <= end_mark ? obj_pkg::scan_idle : obj_pkg::scan_wait_draw;
                obj_pkg::scan_wait_draw: begin
                    if (!inzone) begin          // skip to next entry
                        if (last_addr) begin
                            state <= obj_pkg::scan_idle;
                        end else begin
                            table_addr <= table_addr + 1'b1;
                            n          <= '0;
                            state      <= obj_pkg::scan_fetch;
                        end
                    end else if (dr_idle) begin
                        state <= obj_pkg::scan_issue;
                    end
                end
                obj_pkg::scan_issue: begin
                    dr_start <= ~eff_x[obj_pkg::hpos_w];   // off-screen tiles dropped
                    state    <= obj_pkg::scan_next_tile;
                end
                obj_pkg::scan_next_tile: begin
                    if (n == tile_n) begin      // object done
                        if (last_addr) begin
                            state <= obj_pkg::scan_idle;
                        end else begin
                            table_addr <= table_addr + 1'b1;
                            n          <= '0;
                            state      <= obj_pkg::scan_fetch;
                        end
                    end else begin
                        n     <= n + 1'b1;
                        state <= obj_pkg::scan_check;   // matcher needs the new n
                    end
                end
                default: state <= obj_pkg::scan_idle;
            endcase

            // a new line abandons whatever was left
            if (newline) begin
                state      <= obj_pkg::scan_fetch;
                table_addr <= '0;
                n          <= '0;
            end

            if (newline)
                busy <= 1'b1;
            else if (state == obj_pkg::scan_idle && dr_idle && !dr_start)
                busy <= 1'b0;                   // scan over and last tile drawn
        end
    end

    // request payload, held until the next issue
    always_ff @(posedge clk) begin
        if (newline)
            vrenderf <= vrender ^ obj_pkg::vpos_w'({8{flip}});
        if (state == obj_pkg::scan_issue) begin
            // single tile objects take the code straight from the table
            dr_code <= (tile_n == 4'd0 && tile_m == 4'd0) ? table_code : code_mn;
            dr_attr <= {4'd0, vsub, table_attr[7:0]};
            dr_hpos <= eff_x[obj_pkg::hpos_w-1:0] - obj_pkg::hpos_w'(1);
        end
    end

endmodule

/* hdl/obj_tile_rom.sv */
/*
 * tile pixel memory
 * 16 rows of 16 four-bit pixels per code, pixel 0 in the low nibble
 * host write port, registered read port for the drawer
 */
`timescale 1ns/1ps

module obj_tile_rom #(
    parameter  int rom_codes = 256,
    localparam int rom_aw    = $clog2(rom_codes) + 4   // code then row
) (
    input  logic              clk,

    input  logic              we,
    input  logic [rom_aw-1:0] waddr,
    input  logic [63:0]       wdata,

    input  logic [rom_aw-1:0] raddr,
    output logic [63:0]       rdata
);

    logic [63:0] mem [rom_codes*16];

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];   // one cycle latency
    end

endmodule

/* hdl/obj_draw.sv */
/*
 * tile drawer
 * takes one tile request, reads the tile row and writes its
 * 16 pixels to the line buffer, one per cycle
 * colour 15 pixels are skipped, hflip reverses the columns
 */
`timescale 1ns/1ps

module obj_draw #(
    parameter  int rom_codes = 256,
    localparam int code_w    = $clog2(rom_codes),
    localparam int rom_aw    = code_w + 4
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        start,
    input  logic [15:0]                 code,
    input  logic [15:0]                 attr,    // {4'd0, vsub, attr low byte}
    input  logic [obj_pkg::hpos_w-1:0]  hpos,    // first pixel minus one
    output logic                        idle,

    output logic [rom_aw-1:0]           rom_addr,
    input  logic [63:0]                 rom_data,

    output logic                        buf_we,
    output logic [obj_pkg::hpos_w-1:0]  buf_addr,
    output logic [obj_pkg::pix_w-1:0]   buf_data
);

    obj_pkg::draw_state_e state;

    logic [3:0] cnt;                          // pixel index 0..15
    logic [code_w-1:0] code_l;                // wraps modulo rom_codes
    logic [3:0] vsub_l;
    logic hflip_l;
    logic [4:0] pal_l;
    logic [obj_pkg::hpos_w-1:0] hpos_l;
    logic [3:0] col;
    logic [3:0] pix;

    assign idle     = (state == obj_pkg::draw_idle);
    assign rom_addr = {code_l, vsub_l};
    assign col      = hflip_l ? ~cnt : cnt;   // 15-k under hflip
    assign pix      = rom_data[{col, 2'b00} +: 4];

    assign buf_we   = (state == obj_pkg::draw_write) && (pix != obj_pkg::transp_color);
    assign buf_addr = hpos_l + obj_pkg::hpos_w'(1) + obj_pkg::hpos_w'(cnt);
    assign buf_data = {pal_l, pix};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= obj_pkg::draw_idle;
            cnt   <= '0;
        end else begin
            case (state)
                obj_pkg::draw_idle:
                    if (start) state <= obj_pkg::draw_fetch_row;
                obj_pkg::draw_fetch_row: begin      // row read in flight
                    cnt   <= '0;
                    state <= obj_pkg::draw_write;
                end
                obj_pkg::draw_write: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd15) state <= obj_pkg::draw_idle;
                end
                default: state <= obj_pkg::draw_idle;
            endcase
        end
    end

    // request latch
    always_ff @(posedge clk) begin
        if (idle && start) begin
            code_l  <= code[code_w-1:0];
            vsub_l  <= attr[11:8];
            hflip_l <= attr[5];
            pal_l   <= attr[4:0];
            hpos_l  <= hpos;
        end
    end

endmodule

/* hdl/obj_line_buf.sv */
/*
 * double buffered object line
 * drawer fills the back bank, first opaque write per pixel wins
 * video reads the front bank, each location read is cleared
 * on the next cycle, banks trade places on swap
 */
`timescale 1ns/1ps

module obj_line_buf (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        swap,

    input  logic                        we,
    input  logic [obj_pkg::hpos_w-1:0]  waddr,
    input  logic [obj_pkg::pix_w-1:0]   wdata,

    input  logic [obj_pkg::hpos_w-1:0]  rd_addr,
    output logic [obj_pkg::pix_w-1:0]   rd_pix
);

    localparam int line_len = 2 ** obj_pkg::hpos_w;
    localparam logic [obj_pkg::pix_w-1:0] blank =
        {{(obj_pkg::pix_w-4){1'b1}}, obj_pkg::transp_color};

    logic [obj_pkg::pix_w-1:0] mem [2][line_len];
    logic [1:0][line_len-1:0] valid;            // cleared bit reads as transparent
    logic sel;                                  // back bank, front is ~sel
    logic er_bank;
    logic [obj_pkg::hpos_w-1:0] er_addr;        // last location read
    logic wr_ok;

    assign wr_ok = we && !valid[sel][waddr];    // only over transparent

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel     <= 1'b0;
            valid   <= '0;
            er_bank <= 1'b0;
            er_addr <= '0;
            rd_pix  <= blank;
        end else begin
            if (swap) sel <= ~sel;
            rd_pix  <= valid[~sel][rd_addr] ? mem[~sel][rd_addr] : blank;
            er_bank <= ~sel;
            er_addr <= rd_addr;
            valid[er_bank][er_addr] <= 1'b0;    // erase after read
            if (wr_ok) valid[sel][waddr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) mem[sel][waddr] <= wdata;
    end

endmodule

/* hdl/obj_line_top.sv */
/*
 * object line engine top level
 * frame table, scanner, zone matcher, tile memory, drawer
 * and double buffered line, no glue logic
 */
`timescale 1ns/1ps

module obj_line_top #(
    parameter  int table_depth = 1024,
    parameter  int rom_codes   = 256,
    localparam int rom_aw      = $clog2(rom_codes) + 4
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flip,
    input  logic [obj_pkg::vpos_w-1:0]    vrender,
    input  logic                          line_start,
    // host load ports
    input  logic                          tbl_we,
    input  logic [obj_pkg::table_aw-1:0]  tbl_addr,
    input  logic [obj_pkg::entry_w-1:0]   tbl_data,
    input  logic                          rom_we,
    input  logic [rom_aw-1:0]             rom_addr,
    input  logic [63:0]                   rom_data,
    // video side
    input  logic [obj_pkg::hpos_w-1:0]    hdump,
    output logic [obj_pkg::pix_w-1:0]     obj_pix,
    output logic                          scan_busy
);

    logic [obj_pkg::table_aw-1:0] table_addr;
    logic [obj_pkg::word_w-1:0] t_x, t_y, t_code, t_attr;
    logic inzone;
    logic [3:0] vsub, scan_n;
    logic [15:0] code_mn, dr_code, dr_attr;
    logic [obj_pkg::vpos_w-1:0] vrenderf;
    logic dr_start, dr_idle, newline, buf_we;
    logic [obj_pkg::hpos_w-1:0] dr_hpos, buf_addr;
    logic [obj_pkg::pix_w-1:0] buf_data;
    logic [rom_aw-1:0] tile_addr;
    logic [63:0] tile_row;

    obj_frame_table #(.table_depth(table_depth)) u_table (
        .clk(clk), .we(tbl_we), .waddr(tbl_addr), .wdata(tbl_data),
        .raddr(table_addr), .x(t_x), .y(t_y), .code(t_code), .attr(t_attr));

    obj_tile_match u_match (
        .clk(clk), .obj_code(t_code), .obj_y(t_y[obj_pkg::vpos_w-1:0]),
        .tile_m(t_attr[15:12]), .tile_n(t_attr[11:8]), .n(scan_n),
        .vflip(t_attr[6]), .vrenderf(vrenderf),
        .inzone(inzone), .vsub(vsub), .code_mn(code_mn));

    obj_scan #(.table_depth(table_depth)) u_scan (
        .clk(clk), .rst(rst), .flip(flip), .vrender(vrender), .start(line_start),
        .table_addr(table_addr), .table_x(t_x), .table_y(t_y),
        .table_code(t_code), .table_attr(t_attr),
        .inzone(inzone), .vsub(vsub), .code_mn(code_mn), .n(scan_n), .vrenderf(vrenderf),
        .dr_start(dr_start), .dr_idle(dr_idle), .dr_code(dr_code), .dr_attr(dr_attr),
        .dr_hpos(dr_hpos), .busy(scan_busy), .newline(newline));

    obj_tile_rom #(.rom_codes(rom_codes)) u_rom (
        .clk(clk), .we(rom_we), .waddr(rom_addr), .wdata(rom_data),
        .raddr(tile_addr), .rdata(tile_row));

    obj_draw #(.rom_codes(rom_codes)) u_draw (
        .clk(clk), .rst(rst), .start(dr_start), .code(dr_code), .attr(dr_attr),
        .hpos(dr_hpos), .idle(dr_idle), .rom_addr(tile_addr), .rom_data(tile_row),
        .buf_we(buf_we), .buf_addr(buf_addr), .buf_data(buf_data));

    obj_line_buf u_buf (
        .clk(clk), .rst(rst), .swap(newline),   // banks swap on the line_start edge
        .we(buf_we), .waddr(buf_addr), .wdata(buf_data),
        .rd_addr(hdump), .rd_pix(obj_pix));

endmodule

/* verification/obj_tb_clk.sv */
/*
 * testbench clock and reset source
 * free running clock, reset held high for the first few cycles
 */
`timescale 1ns/1ps

module obj_tb_clk #(
    parameter int period_ns  = 20,
    parameter int rst_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;                         // high from time zero
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* verification/obj_tb.sv */
/*
 * object line engine testbench
 * loads tiles and frame tables through the host ports, builds a line,
 * swaps it to the front bank and reads it back pixel by pixel
 * every pixel is compared with a line model built from the table rules
 */
`timescale 1ns/1ps

module obj_tb;

    localparam int table_depth = 1024;
    localparam int rom_codes   = 256;
    localparam int rom_rows    = rom_codes * 16;
    localparam int clk_period  = 20;
    localparam int num_runs    = 7;                          // line builds over all tests
    localparam longint line_cycles = 1024 * 20 + 600;        // worst case per scan
    localparam longint wd_cycles =
        num_runs * (2 * line_cycles + table_depth + 600) + rom_rows;
    localparam logic [63:0] end_entry = 64'h0000_0000_8000_0000;   // y bit 15 set
    localparam logic [8:0] blank_pix = {5'h1f, obj_pkg::transp_color};

    logic clk;
    logic rst;
    logic flip;
    logic [8:0] vrender;
    logic line_start;
    logic tbl_we;
    logic [9:0] tbl_addr;
    logic [63:0] tbl_data;
    logic rom_we;
    logic [11:0] rom_addr;
    logic [63:0] rom_data;
    logic [8:0] hdump;
    logic [8:0] obj_pix;
    logic scan_busy;

    logic [63:0] tbl_img [table_depth];   // model copy of the frame table
    logic [63:0] rom_img [rom_rows];      // model copy of the tile rows
    string cur_test;
    logic [8:0] cur_line;
    logic cur_flip;
    logic rd_en;
    logic chk_en;
    logic [8:0] chk_addr;
    logic [8:0] exp_pix;
    int test_errs;
    int total_errs;
    int tests_run;
    int tests_failed;

    obj_tb_clk #(.period_ns(clk_period), .rst_cycles(5)) clk_gen (.clk(clk), .rst(rst));

    obj_line_top #(.table_depth(table_depth), .rom_codes(rom_codes)) obj_line_top_i (
        .clk(clk), .rst(rst), .flip(flip), .vrender(vrender), .line_start(line_start),
        .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_data(tbl_data),
        .rom_we(rom_we), .rom_addr(rom_addr), .rom_data(rom_data),
        .hdump(hdump), .obj_pix(obj_pix), .scan_busy(scan_busy));

    function automatic logic [15:0] obj_attr(input int tm, input int tn, input int vf,
                                             input int hf, input int pal);
        return {4'(tm), 4'(tn), 1'b0, 1'(vf), 1'(hf), 5'(pal)};
    endfunction

    function automatic logic [63:0] obj_entry(input int x, input int y, input int code,
                                              input logic [15:0] attr);
        return {attr, 16'(code), 16'(y), 16'(x)};   // x in the low word
    endfunction

    // expected front bank pixel at h where the earliest opaque tile wins
    function automatic logic [8:0] ref_pix(input logic [8:0] h, input logic [8:0] line,
                                           input logic scr_flip);
        logic [63:0] ent;
        logic [63:0] row;
        logic [15:0] ox;
        logic [15:0] oy;
        logic [15:0] ocode;
        logic [15:0] oattr;
        logic [3:0] tm;
        logic [3:0] tn;
        logic [3:0] m;
        logic [3:0] vs;
        logic [3:0] np;
        logic [3:0] col;
        logic [3:0] pix;
        logic [8:0] vf;
        logic [8:0] off;
        logic [8:0] kk;
        logic [9:0] ex;
        logic [7:0] c;
        int e;
        int t;
        vf = scr_flip ? (line ^ 9'h0ff) : line;
        for (e = 0; e < table_depth; e++) begin
            ent   = tbl_img[e];
            ox    = ent[15:0];
            oy    = ent[31:16];
            ocode = ent[47:32];
            oattr = ent[63:48];
            if (oy[15] || oattr[15:8] == 8'hff)
                return blank_pix;                        // end of table
            tm  = oattr[15:12];
            tn  = oattr[11:8];
            off = vf - oy[8:0];                          // mod 512
            if (int'(off) < 16 * (int'(tm) + 1)) begin
                m  = off[7:4];
                vs = off[3:0];
                if (oattr[6]) begin                      // vflip
                    m  = tm - m;
                    vs = ~vs;
                end
                for (t = 0; t <= int'(tn); t++) begin
                    np = oattr[5] ? tn - 4'(t) : 4'(t);  // hflip reverses tile slots
                    ex = ox[9:0] + {2'b00, np, 4'h0};
                    kk = h - ex[8:0];                    // pixel index wrapping round the line
                    if (!ex[9] && kk < 9'd16) begin
                        col = oattr[5] ? 4'd15 - kk[3:0] : kk[3:0];
                        c   = ocode[7:0] + 8'(t) + {m, 4'h0};   // code wraps mod 256
                        row = rom_img[{c, vs}];
                        pix = row[{col, 2'b00} +: 4];
                        if (pix != obj_pkg::transp_color)
                            return {oattr[4:0], pix};
                    end
                end
            end
        end
        return blank_pix;
    endfunction

    // compare each pixel one cycle after its read
    always @(posedge clk) begin
        chk_en   <= rd_en;
        chk_addr <= hdump;
    end

    always @(negedge clk) begin
        if (chk_en) begin
            exp_pix = ref_pix(chk_addr, cur_line, cur_flip);
            assert (obj_pix === exp_pix) else begin
                $display("FAIL %s hdump %0d expected %03h actual %03h",
                         cur_test, chk_addr, exp_pix, obj_pix);
                test_errs++;
            end
        end
    end

    task automatic load_tiles();
        int a;
        for (a = 0; a < rom_rows; a++) begin
            rom_img[a] = {$urandom, $urandom};
            rom_img[a][(a % 16) * 4 +: 4] = obj_pkg::transp_color;  // one hole per row
            @(posedge clk);
            rom_we   <= 1'b1;
            rom_addr <= 12'(a);
            rom_data <= rom_img[a];
        end
        @(posedge clk);
        rom_we <= 1'b0;
    endtask

    task automatic clear_table();
        int e;
        for (e = 0; e < table_depth; e++)
            tbl_img[e] = end_entry;
    endtask

    task automatic write_table();
        int e;
        for (e = 0; e < table_depth; e++) begin
            @(posedge clk);
            tbl_we   <= 1'b1;
            tbl_addr <= 10'(e);
            tbl_data <= tbl_img[e];
        end
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    // scan_busy is due on the cycle after the line_start edge
    task automatic check_busy_rise();
        @(negedge clk);
        assert (scan_busy === 1'b1) else begin
            $display("FAIL %s scan_busy after line_start expected 1 actual %b",
                     cur_test, scan_busy);
            test_errs++;
        end
    endtask

    task automatic wait_scan_done();
        @(negedge clk);
        while (scan_busy)
            @(negedge clk);
    endtask

    task automatic random_table(input int vline);
        int e;
        clear_table();
        for (e = 0; e < 20; e++) begin
            tbl_img[e] = obj_entry($urandom % 560, (vline - int'($urandom % 48)) & 511,
                                   $urandom % 65536,
                                   obj_attr($urandom % 3, $urandom % 3, $urandom % 2,
                                            $urandom % 2, $urandom % 32));
        end
    endtask

    // build one line, swap it to the front and read all 512 pixels
    task automatic run_line(input string name, input int line, input logic scr_flip);
        int i;
        cur_test = name;
        cur_line = 9'(line);
        cur_flip = scr_flip;
        @(posedge clk);
        vrender <= 9'(line);
        flip    <= scr_flip;
        write_table();
        @(posedge clk);
        line_start <= 1'b1;
        @(posedge clk);
        line_start <= 1'b0;
        check_busy_rise();
        wait_scan_done();
        @(posedge clk);                 // empty table so the next scan leaves its bank clean
        tbl_we   <= 1'b1;
        tbl_addr <= '0;
        tbl_data <= end_entry;
        @(posedge clk);
        tbl_we     <= 1'b0;
        line_start <= 1'b1;
        @(posedge clk);                 // banks swap on this edge
        line_start <= 1'b0;
        hdump      <= '0;
        rd_en      <= 1'b1;
        for (i = 1; i < 512; i++) begin
            @(posedge clk);
            hdump <= 9'(i);
        end
        @(posedge clk);
        rd_en <= 1'b0;
        @(posedge clk);
        @(negedge clk);                 // last compare done
        wait_scan_done();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    initial begin
        void'($urandom(32'hf40e8f61));
        flip         = 1'b0;
        vrender      = '0;
        line_start   = 1'b0;
        tbl_we       = 1'b0;
        tbl_addr     = '0;
        tbl_data     = '0;
        rom_we       = 1'b0;
        rom_addr     = '0;
        rom_data     = '0;
        hdump        = '0;
        rd_en        = 1'b0;
        test_errs    = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        @(negedge rst);
        load_tiles();

        clear_table();                                   // row 8 of code 5 at x 40
        tbl_img[0] = obj_entry(40, 92, 5, obj_attr(0, 0, 0, 0, 3));
        run_line("single_tile", 100, 1'b0);
        finish_test("single_tile");

        clear_table();                                   // screen flip puts line 100 at 155
        tbl_img[0] = obj_entry(200, 150, 9, obj_attr(1, 0, 1, 1, 7));
        tbl_img[1] = obj_entry(300, 95, 20, obj_attr(0, 0, 0, 0, 4));    // only unflipped
        tbl_img[2] = obj_entry(100, 140, 33, obj_attr(0, 0, 1, 0, 12));
        run_line("flips", 100, 1'b1);
        finish_test("flips");

        clear_table();                                   // 3 across by 2 down
        tbl_img[0] = obj_entry(64, 84, 16, obj_attr(1, 2, 0, 0, 1));
        tbl_img[1] = obj_entry(256, 100, 40, obj_attr(1, 2, 0, 1, 2));
        run_line("multi_tile", 100, 1'b0);
        finish_test("multi_tile");

        clear_table();
        tbl_img[0] = obj_entry(10, 120, 1, obj_attr(0, 0, 0, 0, 5));     // below the line
        tbl_img[1] = obj_entry(30, 60, 2, obj_attr(0, 0, 0, 0, 5));      // above the line
        tbl_img[2] = obj_entry(500, 100, 3, obj_attr(0, 1, 0, 0, 6));    // 2nd tile off
        tbl_img[3] = obj_entry(600, 100, 4, obj_attr(0, 0, 0, 0, 6));    // bit 9 set
        tbl_img[5] = obj_entry(150, 100, 7, obj_attr(0, 0, 0, 0, 8));    // after marker
        run_line("rejects", 100, 1'b0);
        finish_test("rejects");

        random_table(100);
        run_line("random_overlap", 100, 1'b0);
        random_table(155);
        run_line("random_overlap", 100, 1'b1);
        finish_test("random_overlap");

        clear_table();                                   // bank read above must come back clean
        run_line("erase_after_read", 100, 1'b0);
        finish_test("erase_after_read");

        $display("tests run %0d, failed %0d, pixel mismatches %0d",
                 tests_run, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(wd_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run did not complete", wd_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* vlog.f */
hdl/obj_pkg.sv
hdl/obj_frame_table.sv
hdl/obj_tile_match.sv
hdl/obj_scan.sv
hdl/obj_tile_rom.sv
hdl/obj_draw.sv
hdl/obj_line_buf.sv
hdl/obj_line_top.sv
verification/obj_tb_clk.sv
verification/obj_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the object line engine and its testbench with Verilator, then run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module obj_tb \
    -o obj_tb_sim > build.log 2>&1 \
    && ./obj_dir/obj_tb_sim > sim.log 2>&1 \
    && grep -q "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { tail -n 20 build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
